// ==== design/checkbox_macros.svh ====
// bus widths, port count, window and region codes, register offsets
`ifndef CHECKBOX_MACROS_SVH
`define CHECKBOX_MACROS_SVH

////////////////////
// bus geometry
`define CB_ADDR_W        24
`define CB_DATA_W        32
`define CB_STRB_W        4
`define CB_NUM_PORTS     4
`define CB_WIN_BITS      23:20   // window index, one 1 MB window per AXI port
`define CB_REGION_BITS   19:16   // sub-region code inside a window

////////////////////
// sub-region base codes, each region runs up to the next base
`define CB_REGION_REG    4'h0
`define CB_REGION_CMD    4'h1
`define CB_REGION_WSTRB  4'h3
`define CB_REGION_WDATA  4'h4
`define CB_REGION_RDATA  4'hA

////////////////////
// register offsets in port 0 register region
`define CB_OFS_DELAY     16'h0080  // [7:0] write wait, [15:8] read wait
`define CB_OFS_TEST1     16'h0100
`define CB_OFS_TEST2     16'h0104
`define CB_OFS_TEST3     16'h0108  // always answers with slave error
`define CB_INTR_BASE     16'h2000
`define CB_INTR_SET      8'h00
`define CB_INTR_CLEAR    8'h04
`define CB_INTR_MODE1    8'h08     // pulse mode
`define CB_INTR_MODE2    8'h0C     // re-arm after clear
`define CB_INTR_EN       8'h10
`define CB_HW_INTR_N     4         // bits driven by test_complete

`endif

// ==== design/checkbox_pkg.sv ====
// checkbox typedefs, APB request and window select structs, wait controller phase enum
`include "checkbox_macros.svh"

package checkbox_pkg;

  ////////////////////
  // plain vectors
  typedef logic [`CB_ADDR_W-1:0] apb_addr_t;
  typedef logic [`CB_DATA_W-1:0] apb_data_t;
  typedef logic [`CB_STRB_W-1:0] apb_strb_t;
  typedef logic [7:0]            delay_t;     // wait states per access
  typedef logic [`CB_DATA_W-1:0] intr_vec_t;  // one bit per test interrupt

  ////////////////////
  // APB request as seen by every block
  typedef struct packed {
    logic      sel;
    logic      enable;
    logic      write;
    apb_addr_t addr;
    apb_data_t wdata;
    apb_strb_t strb;
  } apb_req_t;

  // one port window decode result
  typedef struct packed {
    logic      hit;            // address inside this window
    logic      reg_sel;
    logic      cmd_ram_sel;
    logic      wstrb_ram_sel;
    logic      wdata_ram_sel;
    logic      rdata_ram_sel;
    apb_addr_t local_addr;     // address minus window base
  } win_sel_t;

  ////////////////////
  // APB transfer phase
  typedef enum logic [1:0] {
    ph_idle,
    ph_setup,
    ph_access
  } apb_phase_t;

endpackage

// ==== design/apb_wait_ctrl.sv ====
// APB phase FSM, write and read wait counters, pready and write commit strobe
`timescale 1ns/1ps

module apb_wait_ctrl (
  input  logic                   apb_clk,
  input  logic                   apb_rstn,
  input  checkbox_pkg::apb_req_t req,
  input  checkbox_pkg::delay_t   wr_delay,
  input  checkbox_pkg::delay_t   rd_delay,
  output logic                   pready,
  output logic                   wr_commit
);
  import checkbox_pkg::*;

  apb_phase_t phase_q;  // phase of last cycle, idle once a transfer completed
  apb_phase_t phase;    // phase of this cycle
  logic [8:0] wr_cnt_q; // one bit above delay_t so a delay of 255 still ends
  logic [8:0] rd_cnt_q;
  logic [8:0] wr_cnt;
  logic [8:0] rd_cnt;
  logic       delay_done;

  ////////////////////
  // phase tracking
  // access is only entered from setup or a pending access
  always_comb begin
    case (phase_q)
      ph_setup, ph_access: phase = (req.sel && req.enable) ? ph_access : ph_idle;
      default:             phase = (req.sel && !req.enable) ? ph_setup : ph_idle;
    endcase
  end

  ////////////////////
  // wait counters, 0 in setup and k in the k-th access cycle
  always_comb begin
    wr_cnt = wr_cnt_q;
    rd_cnt = rd_cnt_q;
    if (phase == ph_setup) begin
      if (req.write) wr_cnt = '0;
      else           rd_cnt = '0;
    end else if (phase == ph_access) begin
      if (req.write) wr_cnt = wr_cnt_q + 9'd1;
      else           rd_cnt = rd_cnt_q + 9'd1;
    end
  end

  assign delay_done = req.write ? (wr_cnt > {1'b0, wr_delay})
                                : (rd_cnt > {1'b0, rd_delay});
  assign pready     = (phase == ph_access) && delay_done;
  assign wr_commit  = pready && req.write;  // the one edge a write takes effect

  always_ff @(posedge apb_clk or negedge apb_rstn) begin
    if (!apb_rstn) begin
      phase_q  <= ph_idle;
      wr_cnt_q <= '0;
      rd_cnt_q <= '0;
    end else begin
      phase_q  <= pready ? ph_idle : phase;
      wr_cnt_q <= wr_cnt;
      rd_cnt_q <= rd_cnt;
    end
  end

  // completion exactly after the programmed wait states
  a_pready_waits: assert property (@(posedge apb_clk) disable iff (!apb_rstn)
    pready |-> (req.write ? (wr_cnt == {1'b0, wr_delay} + 9'd1)
                          : (rd_cnt == {1'b0, rd_delay} + 9'd1)))
    else $error("pready after wrong number of wait states");

endmodule

// ==== design/port_window.sv ====
// one AXI port window: window match, sub-region decode and window-local address
`timescale 1ns/1ps
`include "checkbox_macros.svh"

module port_window #(
  parameter int PORT_IDX = 0
) (
  input  checkbox_pkg::apb_req_t req,
  output checkbox_pkg::win_sel_t win
);
  import checkbox_pkg::*;

  localparam logic [3:0] WIN_CODE = PORT_IDX[3:0];
  // window base, index placed in the top address nibble
  localparam apb_addr_t  WIN_BASE = {WIN_CODE, {(`CB_ADDR_W-4){1'b0}}};

  logic       hit;
  logic [3:0] region;

  assign hit    = req.sel && (req.addr[`CB_WIN_BITS] == WIN_CODE);
  assign region = req.addr[`CB_REGION_BITS];

  ////////////////////
  // sub-region classify
  // register region spans the single code below the command RAM base
  always_comb begin
    win.hit           = hit;
    win.reg_sel       = hit && (region == `CB_REGION_REG);
    win.cmd_ram_sel   = hit && (region >= `CB_REGION_CMD)
                            && (region <  `CB_REGION_WSTRB);
    win.wstrb_ram_sel = hit && (region >= `CB_REGION_WSTRB)
                            && (region <  `CB_REGION_WDATA);
    win.wdata_ram_sel = hit && (region >= `CB_REGION_WDATA)
                            && (region <  `CB_REGION_RDATA);
    win.rdata_ram_sel = hit && (region >= `CB_REGION_RDATA);  // to top of window
    win.local_addr    = req.addr - WIN_BASE;
  end

endmodule

// ==== design/test_regs.sv ====
// scratch, delay and interrupt control registers with their write logic and readback
`timescale 1ns/1ps
`include "checkbox_macros.svh"

module test_regs (
  input  logic                    apb_clk,
  input  logic                    apb_rstn,
  input  checkbox_pkg::apb_req_t  req,
  input  logic                    wr_commit,
  input  checkbox_pkg::win_sel_t  win0,
  output checkbox_pkg::apb_data_t rd_data,
  output logic                    reg_hit,
  output logic                    err_hit,
  output checkbox_pkg::delay_t    wr_delay,
  output checkbox_pkg::delay_t    rd_delay,
  output checkbox_pkg::intr_vec_t set_pulse,
  output checkbox_pkg::intr_vec_t clear_pulse,
  output checkbox_pkg::intr_vec_t clear_pulse_d,
  output checkbox_pkg::intr_vec_t mode1,
  output checkbox_pkg::intr_vec_t mode2,
  output checkbox_pkg::intr_vec_t intr_en
);
  import checkbox_pkg::*;

  localparam logic [15:0] OFS_DELAY = `CB_OFS_DELAY;
  localparam logic [15:0] OFS_TEST1 = `CB_OFS_TEST1;
  localparam logic [15:0] OFS_TEST2 = `CB_OFS_TEST2;
  localparam logic [15:0] OFS_TEST3 = `CB_OFS_TEST3;
  localparam logic [15:0] INTR_BASE = `CB_INTR_BASE;
  localparam intr_vec_t   HW_MASK   = intr_vec_t'((1 << `CB_HW_INTR_N) - 1);

  logic       test1_sel, test2_sel, test3_sel, delay_sel, intr_sel;
  logic       wr_en;
  logic       mode1_wr;
  logic [7:0] intr_ofs;
  apb_data_t  test1_q, test2_q, delay_q;

  // byte lanes with strobe set take the new data
  function automatic apb_data_t strb_merge(apb_data_t old_val, apb_data_t new_val,
                                           apb_strb_t strb);
    apb_data_t res;
    res = old_val;
    for (int b = 0; b < `CB_STRB_W; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////
  // offset decode, word aligned
  assign test1_sel = win0.reg_sel && (win0.local_addr[15:2] == OFS_TEST1[15:2]);
  assign test2_sel = win0.reg_sel && (win0.local_addr[15:2] == OFS_TEST2[15:2]);
  assign test3_sel = win0.reg_sel && (win0.local_addr[15:2] == OFS_TEST3[15:2]);
  assign delay_sel = win0.reg_sel && (win0.local_addr[15:2] == OFS_DELAY[15:2]);
  assign intr_sel  = win0.reg_sel && (win0.local_addr[15:8] == INTR_BASE[15:8]);
  assign intr_ofs  = win0.local_addr[7:0];

  assign reg_hit  = test1_sel | test2_sel | test3_sel | delay_sel | intr_sel;
  assign err_hit  = test3_sel;
  assign wr_en    = wr_commit && win0.reg_sel;
  assign mode1_wr = wr_en && intr_sel && (intr_ofs == `CB_INTR_MODE1);
  assign wr_delay = delay_q[7:0];
  assign rd_delay = delay_q[15:8];

  ////////////////////
  // register writes
  always_ff @(posedge apb_clk or negedge apb_rstn) begin
    if (!apb_rstn) begin
      test1_q       <= '0;
      test2_q       <= '0;
      delay_q       <= '0;
      set_pulse     <= '0;
      clear_pulse   <= '0;
      clear_pulse_d <= '0;
      mode1         <= '0;
      mode2         <= '0;
      intr_en       <= '0;
    end else begin
      set_pulse     <= '0;           // single cycle pulses
      clear_pulse   <= '0;
      clear_pulse_d <= clear_pulse;  // re-arm trigger
      if (wr_en) begin
        if (test1_sel)      test1_q <= strb_merge(test1_q, req.wdata, req.strb);
        else if (test2_sel) test2_q <= strb_merge(test2_q, req.wdata, req.strb);
        else if (delay_sel) delay_q <= req.wdata;
        else if (intr_sel) begin
          case (intr_ofs)
            `CB_INTR_SET:   set_pulse   <= req.wdata;
            `CB_INTR_CLEAR: clear_pulse <= req.wdata;
            `CB_INTR_MODE1: mode1       <= req.wdata | HW_MASK;   // hw bits always pulse
            `CB_INTR_MODE2: mode2       <= req.wdata & ~HW_MASK;  // hw bits never re-arm
            `CB_INTR_EN:    intr_en     <= req.wdata;
            default: ;
          endcase
        end
      end
    end
  end

  ////////////////////
  // readback
  always_comb begin
    rd_data = '0;
    if (test1_sel)      rd_data = test1_q;
    else if (test2_sel) rd_data = test2_q;
    else if (delay_sel) rd_data = delay_q;
    else if (intr_sel) begin
      case (intr_ofs)
        `CB_INTR_SET:   rd_data = set_pulse;
        `CB_INTR_CLEAR: rd_data = clear_pulse;
        `CB_INTR_MODE1: rd_data = mode1;
        `CB_INTR_MODE2: rd_data = mode2;
        `CB_INTR_EN:    rd_data = intr_en;
        default:        rd_data = '0;
      endcase
    end
  end

  // once written, the hw nibble of mode1 never drops again
  a_mode1_hw: assert property (@(posedge apb_clk) disable iff (!apb_rstn)
    (mode1_wr || (mode1 & HW_MASK) == HW_MASK) |=> (mode1 & HW_MASK) == HW_MASK)
    else $error("mode1 hw bits lost after write");

endmodule

// ==== design/intr_gen.sv ====
// test interrupt state bits with set, clear, pulse and re-arm modes and enable mask
`timescale 1ns/1ps
`include "checkbox_macros.svh"

module intr_gen (
  input  logic                         apb_clk,
  input  logic                         apb_rstn,
  input  logic [`CB_HW_INTR_N-1:0]     test_complete,
  input  checkbox_pkg::intr_vec_t      set_pulse,
  input  checkbox_pkg::intr_vec_t      clear_pulse,
  input  checkbox_pkg::intr_vec_t      clear_pulse_d,
  input  checkbox_pkg::intr_vec_t      mode1,
  input  checkbox_pkg::intr_vec_t      mode2,
  input  checkbox_pkg::intr_vec_t      intr_en,
  output checkbox_pkg::intr_vec_t      intr_out
);
  import checkbox_pkg::*;

  // low bits follow test_complete, the rest are software driven
  localparam intr_vec_t HW_MASK = intr_vec_t'((1 << `CB_HW_INTR_N) - 1);

  intr_vec_t intr_q;
  intr_vec_t hw_set;
  intr_vec_t sw_set;
  intr_vec_t rise;
  intr_vec_t fall;

  ////////////////////
  // per bit set and clear terms
  assign hw_set = intr_vec_t'(test_complete);
  // set write, or one cycle after a clear when re-arm is on
  assign sw_set = ~intr_q & (set_pulse | (clear_pulse_d & mode2));
  assign rise   = (hw_set & HW_MASK) | (sw_set & ~HW_MASK);

  // cleared by write, or right after rising in pulse mode
  assign fall   = intr_q & (clear_pulse | mode1);

  always_ff @(posedge apb_clk or negedge apb_rstn) begin
    if (!apb_rstn) begin
      intr_q <= '0;
    end else begin
      intr_q <= rise | (intr_q & ~fall);  // test_complete wins over clear
    end
  end

  assign intr_out = intr_q & intr_en;

endmodule

// ==== design/read_mux.sv ====
// APB read data and slave error select across port windows and register readback
`timescale 1ns/1ps
`include "checkbox_macros.svh"

module read_mux (
  input  checkbox_pkg::win_sel_t  win [`CB_NUM_PORTS],
  input  checkbox_pkg::apb_data_t port_rdata [`CB_NUM_PORTS],
  input  checkbox_pkg::apb_data_t reg_rd_data,
  input  logic                    reg_hit,
  input  logic                    err_hit,
  output checkbox_pkg::apb_data_t prdata,
  output logic                    pslverr
);
  import checkbox_pkg::*;

  logic [`CB_NUM_PORTS-1:0] hits;
  apb_data_t                win0_data;

  for (genvar i = 0; i < `CB_NUM_PORTS; i++) begin : g_hit
    assign hits[i] = win[i].hit;
  end

  // port 0 registers shadow its downstream data
  assign win0_data = reg_hit ? reg_rd_data : port_rdata[0];

  ////////////////////
  // window select, unmapped reads return zero
  always_comb begin
    prdata = '0;
    for (int i = 0; i < `CB_NUM_PORTS; i++) begin
      if (hits[i]) begin
        prdata = (i == 0) ? win0_data : port_rdata[i];
      end
    end
  end

  assign pslverr = err_hit;

  // window decoders must never overlap
  always_comb begin
    assert final ($onehot0(hits))
      else $error("more than one port window hit");
  end

endmodule

// ==== design/checkbox_apb_top.sv ====
// checkbox APB slave top: port window array, wait control, test registers, interrupts
`timescale 1ns/1ps
`include "checkbox_macros.svh"

module checkbox_apb_top (
  input  logic                    apb_clk,
  input  logic                    apb_rstn,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  checkbox_pkg::apb_addr_t paddr,
  input  checkbox_pkg::apb_data_t pwdata,
  input  checkbox_pkg::apb_strb_t pstrb,
  input  checkbox_pkg::apb_data_t port_rdata [`CB_NUM_PORTS],
  input  logic [`CB_HW_INTR_N-1:0] test_complete,
  output checkbox_pkg::apb_data_t prdata,
  output logic                    pready,
  output logic                    pslverr,
  output checkbox_pkg::win_sel_t  port_sel [`CB_NUM_PORTS],
  output checkbox_pkg::intr_vec_t intr_out
);
  import checkbox_pkg::*;

  apb_req_t  req;
  delay_t    wr_delay, rd_delay;
  logic      wr_commit;
  apb_data_t reg_rd_data;
  logic      reg_hit, err_hit;
  intr_vec_t set_pulse, clear_pulse, clear_pulse_d;
  intr_vec_t mode1, mode2, intr_en;

  ////////////////////
  // APB pins to request struct
  assign req.sel    = psel;
  assign req.enable = penable;
  assign req.write  = pwrite;
  assign req.addr   = paddr;
  assign req.wdata  = pwdata;
  assign req.strb   = pstrb;

  apb_wait_ctrl wait_i (
    .apb_clk, .apb_rstn, .req, .wr_delay, .rd_delay, .pready, .wr_commit
  );

  for (genvar i = 0; i < `CB_NUM_PORTS; i++) begin : g_port
    port_window #(.PORT_IDX(i)) win_i (
      .req (req),
      .win (port_sel[i])
    );
  end

  test_regs regs_i (
    .apb_clk, .apb_rstn, .req, .wr_commit,
    .win0 (port_sel[0]),
    .rd_data (reg_rd_data),
    .reg_hit, .err_hit, .wr_delay, .rd_delay,
    .set_pulse, .clear_pulse, .clear_pulse_d, .mode1, .mode2, .intr_en
  );

  intr_gen intr_i (
    .apb_clk, .apb_rstn, .test_complete,
    .set_pulse, .clear_pulse, .clear_pulse_d, .mode1, .mode2, .intr_en, .intr_out
  );

  read_mux rmux_i (
    .win (port_sel), .port_rdata, .reg_rd_data, .reg_hit, .err_hit, .prdata, .pslverr
  );

endmodule

// ==== testbench/tb_checkbox.sv ====
// testbench for the checkbox APB slave: clock, reset, APB driver, reference model, compare, watchdog
`timescale 1ns/1ps
`include "checkbox_macros.svh"

module tb_checkbox;
  import checkbox_pkg::*;

  localparam int N_XFERS   = 300;  // upper bound on transfers in the whole run
  localparam int MAX_DELAY = 5;
  localparam int LIMIT     = N_XFERS * (MAX_DELAY + 4) + 200;
  localparam apb_addr_t A_DELAY = apb_addr_t'(`CB_OFS_DELAY);
  localparam apb_addr_t A_TEST1 = apb_addr_t'(`CB_OFS_TEST1);
  localparam apb_addr_t A_TEST2 = apb_addr_t'(`CB_OFS_TEST2);
  localparam apb_addr_t A_TEST3 = apb_addr_t'(`CB_OFS_TEST3);
  localparam apb_addr_t A_SET   = apb_addr_t'(`CB_INTR_BASE + `CB_INTR_SET);
  localparam apb_addr_t A_CLEAR = apb_addr_t'(`CB_INTR_BASE + `CB_INTR_CLEAR);
  localparam apb_addr_t A_MODE1 = apb_addr_t'(`CB_INTR_BASE + `CB_INTR_MODE1);
  localparam apb_addr_t A_MODE2 = apb_addr_t'(`CB_INTR_BASE + `CB_INTR_MODE2);
  localparam apb_addr_t A_EN    = apb_addr_t'(`CB_INTR_BASE + `CB_INTR_EN);
  localparam intr_vec_t SW_MASK = 32'hFFFF_FFF0;

  logic                     apb_clk;
  logic                     apb_rstn;
  logic                     psel, penable, pwrite;
  apb_addr_t                paddr;
  apb_data_t                pwdata;
  apb_strb_t                pstrb;
  apb_data_t                port_rdata [`CB_NUM_PORTS];
  logic [`CB_HW_INTR_N-1:0] test_complete;
  apb_data_t                prdata;
  logic                     pready, pslverr;
  win_sel_t                 port_sel [`CB_NUM_PORTS];
  win_sel_t                 sel_snap [`CB_NUM_PORTS];
  intr_vec_t                intr_out;

  // shadow register state
  apb_data_t   test1_m, test2_m, delay_m, mode1_m, mode2_m, en_m;
  logic [31:0] rng;
  logic [63:0] got_q [$];
  logic [63:0] exp_q [$];
  string       msg_q [$];
  int          checks, errors, c0, e0;

  checkbox_apb_top dut_i (.*);

  initial apb_clk = 1'b0;
  always #2 apb_clk = ~apb_clk;

  ////////////////////
  // helpers
  function automatic logic [31:0] next_rand();
    rng ^= rng << 13;
    rng ^= rng >> 17;
    rng ^= rng << 5;
    return rng;
  endfunction

  function automatic apb_data_t byte_merge(apb_data_t old_v, apb_data_t new_v, apb_strb_t s);
    apb_data_t res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) res[b*8 +: 8] = new_v[b*8 +: 8];
    end
    return res;
  endfunction

  // expected decode of one port window
  function automatic win_sel_t exp_win(int p, apb_addr_t a);
    win_sel_t   e;
    logic [3:0] r;
    r               = a[19:16];
    e.hit           = (a[23:20] == p[3:0]);
    e.reg_sel       = e.hit && (r == 4'h0);
    e.cmd_ram_sel   = e.hit && (r == 4'h1 || r == 4'h2);
    e.wstrb_ram_sel = e.hit && (r == 4'h3);
    e.wdata_ram_sel = e.hit && (r >= 4'h4) && (r <= 4'h9);
    e.rdata_ram_sel = e.hit && (r >= 4'hA);
    e.local_addr    = a - apb_addr_t'(p << 20);
    return e;
  endfunction

  // expected prdata for a read at a
  function automatic apb_data_t cb_model(apb_addr_t a);
    logic [3:0]  w;
    logic [15:0] ofs;
    w   = a[23:20];
    ofs = a[15:0];
    if (w >= 4) return '0;                          // unmapped windows
    if (w != 0 || a[19:16] != 4'h0) return port_rdata[w];
    if (ofs[15:2] == A_TEST1[15:2]) return test1_m;
    if (ofs[15:2] == A_TEST2[15:2]) return test2_m;
    if (ofs[15:2] == A_TEST3[15:2]) return '0;
    if (ofs[15:2] == A_DELAY[15:2]) return delay_m;
    if (ofs[15:8] == 8'h20) begin
      case (ofs[7:0])
        `CB_INTR_MODE1: return mode1_m;
        `CB_INTR_MODE2: return mode2_m;
        `CB_INTR_EN:    return en_m;
        default:        return '0;                  // set and clear pulses idle
      endcase
    end
    return port_rdata[0];
  endfunction

  task automatic check(logic [63:0] got, logic [63:0] exp, string what);
    got_q.push_back(got);
    exp_q.push_back(exp);
    msg_q.push_back(what);
  endtask

  ////////////////////
  // compare process
  always @(posedge apb_clk) begin : compare
    logic [63:0] g, e;
    string       m;
    while (exp_q.size() > 0) begin
      g = got_q.pop_front();
      e = exp_q.pop_front();
      m = msg_q.pop_front();
      checks++;
      assert (g === e) else begin
        $display("MISMATCH at time %0t: %s got %0h expected %0h", $time, m, g, e);
        errors++;
      end
    end
  end

  task automatic start_test();
    c0 = checks;
    e0 = errors;
  endtask

  task automatic end_test(string name);
    while (exp_q.size() != 0) @(posedge apb_clk);
    $display("test %s checks %0d errors %0d", name, checks - c0, errors - e0);
  endtask

  ////////////////////
  // APB transfer, returns just after the completing edge
  task automatic xfer(input logic wr, input apb_addr_t a, input apb_data_t d,
                      input apb_strb_t s, output apb_data_t rd, output logic err,
                      output int waits);
    @(posedge apb_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= a;
    pwdata  <= d;
    pstrb   <= s;
    @(posedge apb_clk);
    penable <= 1'b1;
    waits = 0;
    forever begin
      @(negedge apb_clk);
      if (pready) break;
      waits++;
    end
    rd       = prdata;
    err      = pslverr;
    sel_snap = port_sel;
    @(posedge apb_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic wr(apb_addr_t a, apb_data_t d);
    apb_data_t rd;
    logic      err;
    int        waits;
    xfer(1'b1, a, d, 4'hF, rd, err, waits);
  endtask

  task automatic next_intr(output intr_vec_t v);
    @(negedge apb_clk);
    v = intr_out;
  endtask

  ////////////////////
  // watchdog
  initial begin
    repeat (LIMIT) @(posedge apb_clk);
    $display("watchdog: tests did not finish within %0d cycles", LIMIT);
    $display("Simulation failed");
    $finish;
  end

  initial begin : stim
    apb_data_t  d, rd, r;
    apb_addr_t  a;
    apb_strb_t  s;
    logic       err;
    int         waits, dw, dr;
    logic [3:0] w;
    intr_vec_t  v, x;
    rng = 32'hcdcd_d5e8;
    checks = 0;
    errors = 0;
    {test1_m, test2_m, delay_m, mode1_m, mode2_m, en_m} = '0;
    apb_rstn = 1'b0;
    {psel, penable, pwrite} = '0;
    paddr = '0;
    pwdata = '0;
    pstrb = '0;
    test_complete = '0;
    for (int i = 0; i < `CB_NUM_PORTS; i++) port_rdata[i] = '0;
    repeat (8) @(posedge apb_clk);
    apb_rstn <= 1'b1;

    // scratch registers with byte strobes
    start_test();
    for (int i = 0; i < 16; i++) begin
      a = (i % 2) ? A_TEST2 : A_TEST1;
      d = next_rand();
      r = next_rand();
      s = r[3:0];
      xfer(1'b1, a, d, s, rd, err, waits);
      if (a == A_TEST1) test1_m = byte_merge(test1_m, d, s);
      else              test2_m = byte_merge(test2_m, d, s);
      xfer(1'b0, a, '0, '0, rd, err, waits);
      check(rd, cb_model(a), "scratch readback");
    end
    end_test("scratch strobes");

    // wait states
    start_test();
    for (int i = 0; i < 3; i++) begin
      dw = next_rand() % (MAX_DELAY + 1);
      dr = next_rand() % (MAX_DELAY + 1);
      delay_m = {16'h0, 8'(dr), 8'(dw)};
      wr(A_DELAY, delay_m);
      test1_m = next_rand();
      xfer(1'b1, A_TEST1, test1_m, 4'hF, rd, err, waits);
      check(64'(waits), 64'(dw), "write wait states");
      xfer(1'b0, A_TEST1, '0, '0, rd, err, waits);
      check(64'(waits), 64'(dr), "read wait states");
      check(rd, cb_model(A_TEST1), "read data after waits");
    end
    end_test("wait states");

    // window decode and read mux
    start_test();
    @(posedge apb_clk);
    for (int i = 0; i < `CB_NUM_PORTS; i++) port_rdata[i] <= next_rand();
    for (int i = 0; i < 40; i++) begin
      w = 4'(next_rand() % 6);                      // 4 and 5 are unmapped
      r = next_rand();
      a = {w, r[19:2], 2'b00};
      if (w == 0 && a[19:16] == 4'h0) a[19:16] = 4'h1;
      xfer(1'b0, a, '0, '0, rd, err, waits);
      check(rd, cb_model(a), "window read data");
      check(64'(err), 64'd0, "window pslverr");
      for (int p = 0; p < `CB_NUM_PORTS; p++) begin
        check(64'(sel_snap[p]), 64'(exp_win(p, a)), "port_sel decode");
      end
    end
    end_test("window decode");

    // slave error register
    start_test();
    xfer(1'b0, A_TEST3, '0, '0, rd, err, waits);
    check(64'(err), 64'd1, "test3 read pslverr");
    check(rd, 64'd0, "test3 read data");
    xfer(1'b1, A_TEST3, 32'hFFFF_FFFF, 4'hF, rd, err, waits);
    check(64'(err), 64'd1, "test3 write pslverr");
    xfer(1'b0, A_TEST1, '0, '0, rd, err, waits);
    check(64'(err), 64'd0, "test1 pslverr");
    xfer(1'b0, A_DELAY, '0, '0, rd, err, waits);
    check(64'(err), 64'd0, "delay pslverr");
    check(rd, cb_model(A_DELAY), "delay readback");
    end_test("slave error");

    // hardware interrupt bits, mode1 still unwritten so they latch
    start_test();
    en_m = 32'hFFFF_FFFF;
    wr(A_EN, en_m);
    @(posedge apb_clk);
    test_complete <= 4'b1010;
    @(posedge apb_clk);
    test_complete <= 4'b0000;
    repeat (3) next_intr(v);
    check(v, 64'h0000_000A, "test_complete latched");
    wr(A_CLEAR, 32'h0000_000F);
    repeat (2) next_intr(v);
    check(v, 64'd0, "test_complete cleared");
    end_test("hw interrupts");

    // software interrupt bits
    start_test();
    en_m = next_rand();
    wr(A_EN, en_m);
    xfer(1'b0, A_EN, '0, '0, rd, err, waits);
    check(rd, cb_model(A_EN), "enable readback");
    r = next_rand();
    x = r & en_m & SW_MASK;
    wr(A_SET, r);
    next_intr(v);
    check(v, 64'd0, "set before edge");
    next_intr(v);
    check(v, x, "set raised");
    wr(A_CLEAR, 32'hFFFF_FFFF);
    next_intr(v);
    check(v, x, "clear before edge");
    next_intr(v);
    check(v, 64'd0, "clear dropped");

    // pulse mode
    mode1_m = 32'hFFFF_0000 | 32'h0000_000F;
    wr(A_MODE1, 32'hFFFF_0000);
    xfer(1'b0, A_MODE1, '0, '0, rd, err, waits);
    check(rd, cb_model(A_MODE1), "mode1 readback");
    wr(A_SET, r);
    next_intr(v);
    next_intr(v);
    check(v, x, "pulse mode rise");
    next_intr(v);
    check(v, x & ~mode1_m, "pulse mode fall");
    wr(A_CLEAR, 32'hFFFF_FFFF);
    repeat (2) next_intr(v);

    // re-arm mode, every cleared bit with mode2 set comes back
    mode1_m = 32'h0000_000F;
    wr(A_MODE1, 32'h0);
    mode2_m = 32'hFFFF_FFFF & SW_MASK;
    wr(A_MODE2, 32'hFFFF_FFFF);
    xfer(1'b0, A_MODE2, '0, '0, rd, err, waits);
    check(rd, cb_model(A_MODE2), "mode2 readback");
    wr(A_SET, r);
    repeat (2) next_intr(v);
    check(v, x, "re-arm set");
    wr(A_CLEAR, 32'hFFFF_FFFF);
    next_intr(v);
    next_intr(v);
    check(v, 64'd0, "re-arm cleared");
    next_intr(v);
    check(v, 32'hFFFF_FFFF & mode2_m & en_m, "re-arm reasserted");
    mode2_m = '0;
    wr(A_MODE2, 32'h0);
    wr(A_CLEAR, 32'hFFFF_FFFF);
    repeat (3) next_intr(v);
    check(v, 64'd0, "final clear");
    end_test("sw interrupts");

    $display("total checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== checkbox.f ====
+incdir+design
design/checkbox_pkg.sv
design/apb_wait_ctrl.sv
design/port_window.sv
design/test_regs.sv
design/intr_gen.sv
design/read_mux.sv
design/checkbox_apb_top.sv
testbench/tb_checkbox.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_checkbox
FILELIST  := checkbox.f
OBJ_DIR   := obj_dir
PASS_MSG  := Simulation completed successfully

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard design/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
